// ==== ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// Data path width
`define WORD_WIDTH 32

// Register file index where entry 0 is the zero register
`define REG_ADDR_WIDTH 5

// Raw immediate field of I-type instructions
`define IMM_WIDTH 16

// Constant shift amount field
`define SHAMT_WIDTH 5

// Decoded instruction identifier
`define INSTR_WIDTH 6

`endif

// ==== exPkg.sv ====
`include "ex_defines.svh"

package exPkg;

    typedef logic [`WORD_WIDTH-1:0]     wordT;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;   // Entry 0 reads as zero and is never written
    typedef logic [`IMM_WIDTH-1:0]      imm16T;
    typedef logic [`SHAMT_WIDTH-1:0]    shamtT;

    // Identifiers as produced by decode
    typedef enum logic [`INSTR_WIDTH-1:0] {
        NOP = 0,
        ADD, ADDU, SUB, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        SLLV, SRLV, SRAV,
        ADDI, ADDIU, ANDI, ORI, XORI,
        SLTI, SLTIU, LUI,
        LW, SW,
        JAL
    } instrT;

    typedef enum logic [1:0] {
        FMT_R,
        FMT_I,
        FMT_J
    } formatT;

    typedef enum logic [2:0] {
        FN_NONE,
        FN_CALC_R,
        FN_CALC_I,
        FN_MEM_READ,
        FN_MEM_WRITE,
        FN_JUMP
    } funcT;

    typedef enum logic [3:0] {
        OP_ZERO,
        OP_ADD, OP_SUB,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU,
        OP_SLL, OP_SRL, OP_SRA,
        OP_LUI
    } aluOpT;

    // Decode to execute
    typedef struct packed {
        instrT   instr;
        wordT    pc;
        regAddrT rsAddr;
        regAddrT rtAddr;
        wordT    dataRs;
        wordT    dataRt;
        imm16T   imm16;
        shamtT   shamt;
        regAddrT regWriteAddr;
        wordT    regWriteData;  // Precomputed value such as PC+8 for JAL
    } exInT;

    // Execute to memory
    typedef struct packed {
        instrT   instr;
        wordT    pc;
        wordT    aluOut;
        wordT    memWriteData;
        regAddrT regWriteAddr;
        wordT    regWriteData;
    } exMemT;

    // Result still in flight in a later stage
    typedef struct packed {
        regAddrT addr;
        wordT    data;
    } fwdT;

endpackage

// ==== instrClassifier.sv ====
`timescale 1ns/1ps

module instrClassifier (
    input  exPkg::instrT  instr,
    output exPkg::formatT format,
    output exPkg::funcT   func
);
    import exPkg::*;

    always_comb begin
        case (instr)
            ADD, ADDU, SUB, SUBU,
            AND, OR, XOR, NOR,
            SLT, SLTU,
            SLL, SRL, SRA,
            SLLV, SRLV, SRAV: begin
                format = FMT_R;
                func   = FN_CALC_R;
            end
            ADDI, ADDIU, ANDI, ORI, XORI,
            SLTI, SLTIU, LUI: begin
                format = FMT_I;
                func   = FN_CALC_I;
            end
            LW: begin
                format = FMT_I;
                func   = FN_MEM_READ;
            end
            SW: begin
                format = FMT_I;
                func   = FN_MEM_WRITE;
            end
            JAL: begin
                format = FMT_J;
                func   = FN_JUMP;
            end
            default: begin          // NOP and unused codes
                format = FMT_R;
                func   = FN_NONE;
            end
        endcase
    end

    // Every real instruction lands in a class and only NOP is classless
    assert property (@(instr)
        (instr inside {[ADD:JAL]}) |-> (!$isunknown(func) && func != FN_NONE))
    else $error("instrClassifier: no class for instr %0d", instr);

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "ex_defines.svh"

module alu (
    input  exPkg::instrT instr,
    input  exPkg::wordT  opRs,
    input  exPkg::wordT  opRt,
    input  exPkg::imm16T imm16,
    input  exPkg::shamtT shamt,
    output exPkg::wordT  result
);
    import exPkg::*;

    formatT format;
    funcT   func;
    aluOpT  aluOp;
    logic   signExt;
    wordT   extImm;
    wordT   srcA;
    wordT   srcB;
    shamtT  shAmt;

    instrClassifier classInst (
        .instr (instr),
        .format(format),
        .func  (func)
    );

    // Operation select
    always_comb begin
        if (func == FN_MEM_READ || func == FN_MEM_WRITE) begin
            aluOp = OP_ADD;     // Address = base + offset
        end else begin
            case (instr)
                ADD, ADDU, ADDI, ADDIU: aluOp = OP_ADD;
                SUB, SUBU:              aluOp = OP_SUB;
                AND, ANDI:              aluOp = OP_AND;
                OR, ORI:                aluOp = OP_OR;
                XOR, XORI:              aluOp = OP_XOR;
                NOR:                    aluOp = OP_NOR;
                SLT, SLTI:              aluOp = OP_SLT;
                SLTU, SLTIU:            aluOp = OP_SLTU;
                SLL, SLLV:              aluOp = OP_SLL;
                SRL, SRLV:              aluOp = OP_SRL;
                SRA, SRAV:              aluOp = OP_SRA;
                LUI:                    aluOp = OP_LUI;
                default:                aluOp = OP_ZERO;
            endcase
        end
    end

    // Logical immediates are zero extended
    assign signExt = !(instr inside {ANDI, ORI, XORI, LUI});

    always_comb begin
        if (signExt) begin
            extImm = {{(`WORD_WIDTH-`IMM_WIDTH){imm16[`IMM_WIDTH-1]}}, imm16};
        end else begin
            extImm = {{(`WORD_WIDTH-`IMM_WIDTH){1'b0}}, imm16};
        end
    end

    // Constant shifts take the amount from the shamt field
    always_comb begin
        if (instr inside {SLL, SRL, SRA}) begin
            srcA = {{(`WORD_WIDTH-`SHAMT_WIDTH){1'b0}}, shamt};
        end else begin
            srcA = opRs;
        end
    end

    assign srcB  = (format == FMT_I) ? extImm : opRt;
    assign shAmt = srcA[`SHAMT_WIDTH-1:0];  // Variable shifts use low bits of rs

    always_comb begin
        case (aluOp)
            OP_ADD:  result = srcA + srcB;
            OP_SUB:  result = srcA - srcB;
            OP_AND:  result = srcA & srcB;
            OP_OR:   result = srcA | srcB;
            OP_XOR:  result = srcA ^ srcB;
            OP_NOR:  result = ~(srcA | srcB);
            OP_SLT: begin
                result = {{(`WORD_WIDTH-1){1'b0}}, ($signed(srcA) < $signed(srcB))};
            end
            OP_SLTU: begin
                result = {{(`WORD_WIDTH-1){1'b0}}, (srcA < srcB)};
            end
            OP_SLL:  result = srcB << shAmt;
            OP_SRL:  result = srcB >> shAmt;
            OP_SRA:  result = $signed(srcB) >>> shAmt;     // Sign fill
            OP_LUI:  result = {srcB[`IMM_WIDTH-1:0], {`IMM_WIDTH{1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

// ==== forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
    input  exPkg::regAddrT rsAddr,
    input  exPkg::regAddrT rtAddr,
    input  exPkg::wordT    dataRs,
    input  exPkg::wordT    dataRt,
    input  exPkg::fwdT     fwdMem,
    input  exPkg::fwdT     fwdWb,
    output exPkg::wordT    opRs,
    output exPkg::wordT    opRt
);
    import exPkg::*;

    // Newest matching value for one operand
    function automatic wordT pickOperand(
        input regAddrT addr,
        input wordT    regData,
        input fwdT     memSrc,
        input fwdT     wbSrc
    );
        wordT picked;

        picked = regData;
        if (addr != '0) begin                   // Zero register is never replaced
            if (memSrc.addr == addr) begin
                picked = memSrc.data;           // MEM is younger than WB
            end else if (wbSrc.addr == addr) begin
                picked = wbSrc.data;
            end
        end
        return picked;
    endfunction

    assign opRs = pickOperand(rsAddr, dataRs, fwdMem, fwdWb);
    assign opRt = pickOperand(rtAddr, dataRt, fwdMem, fwdWb);

endmodule

// ==== exStage.sv ====
`timescale 1ns/1ps

module exStage (
    input  logic         clk,
    input  logic         arstN,
    input  logic         stall,
    input  logic         clr,
    input  exPkg::exInT  exIn,
    input  exPkg::fwdT   fwdMem,
    input  exPkg::fwdT   fwdWb,
    output exPkg::exMemT exMem
);
    import exPkg::*;

    wordT  opRs;
    wordT  opRt;
    wordT  aluResult;
    funcT  func;
    exMemT exMemNext;

    forwardUnit fwdUnit (
        .rsAddr(exIn.rsAddr),
        .rtAddr(exIn.rtAddr),
        .dataRs(exIn.dataRs),
        .dataRt(exIn.dataRt),
        .fwdMem(fwdMem),
        .fwdWb (fwdWb),
        .opRs  (opRs),
        .opRt  (opRt)
    );

    alu aluInst (
        .instr (exIn.instr),
        .opRs  (opRs),
        .opRt  (opRt),
        .imm16 (exIn.imm16),
        .shamt (exIn.shamt),
        .result(aluResult)
    );

    // Only the class is needed here
    instrClassifier classInst (
        .instr (exIn.instr),
        .format(),
        .func  (func)
    );

    always_comb begin
        exMemNext.instr        = exIn.instr;
        exMemNext.pc           = exIn.pc;
        exMemNext.aluOut       = aluResult;
        exMemNext.memWriteData = opRt;              // Store data after forwarding
        exMemNext.regWriteAddr = exIn.regWriteAddr;
        case (func)
            FN_CALC_R, FN_CALC_I: exMemNext.regWriteData = aluResult;
            default:              exMemNext.regWriteData = exIn.regWriteData;
        endcase
    end

    // EX/MEM register where clr beats stall
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else if (clr) begin
            exMem <= '0;                // Bubble
        end else if (!stall) begin
            exMem <= exMemNext;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        (stall && !clr) |=> $stable(exMem))
    else $error("exStage: exMem changed during stall");

    assert property (@(posedge clk) disable iff (!arstN)
        clr |=> (exMem.instr == NOP))
    else $error("exStage: no bubble after clr");

    // A bubble must never write the register file
    assert property (@(posedge clk) disable iff (!arstN)
        (exMem.instr == NOP) |-> (exMem.regWriteAddr == '0))
    else $error("exStage: NOP carries a register write");

endmodule

// ==== exStageTb.sv ====
`timescale 1ns/1ps

module exStageTb;
    import exPkg::*;

    localparam int  CLK_PERIOD   = 20;
    localparam int  RESET_CYCLES = 8;
    localparam int  MAX_CYCLES   = 2000;    // Tests take about 310 cycles
    localparam fwdT NO_FWD       = '0;      // Address 0 never matches

    logic  clk;
    logic  arstN;
    logic  stall;
    logic  clr;
    exInT  exIn;
    fwdT   fwdMem;
    fwdT   fwdWb;
    exMemT exMem;

    int seed;
    int errors;
    int checks;
    int cycleCount;

    exStage UUT (
        .clk   (clk),
        .arstN (arstN),
        .stall (stall),
        .clr   (clr),
        .exIn  (exIn),
        .fwdMem(fwdMem),
        .fwdWb (fwdWb),
        .exMem (exMem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Run limit
    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // Newest value for one operand with the zero register excluded
    function automatic wordT forwardedValue(input regAddrT addr, input wordT decoded,
                                            input fwdT memSrc, input fwdT wbSrc);
        if (addr == 0)
            return decoded;
        if (memSrc.addr == addr)
            return memSrc.data;
        if (wbSrc.addr == addr)
            return wbSrc.data;
        return decoded;
    endfunction

    function automatic wordT expectedAlu(input instrT op, input wordT rs, input wordT rt,
                                         input imm16T imm, input shamtT sh);
        wordT sImm;
        wordT zImm;
        wordT r;

        sImm = {{16{imm[15]}}, imm};
        zImm = {16'h0000, imm};
        case (op)
            ADD, ADDU:   r = rs + rt;
            SUB, SUBU:   r = rs - rt;
            AND:         r = rs & rt;
            OR:          r = rs | rt;
            XOR:         r = rs ^ rt;
            NOR:         r = ~(rs | rt);
            SLT:         r = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
            SLTU:        r = (rs < rt) ? 32'd1 : 32'd0;
            SLL:         r = rt << sh;
            SRL:         r = rt >> sh;
            SRA:         r = $signed(rt) >>> sh;
            SLLV:        r = rt << rs[4:0];
            SRLV:        r = rt >> rs[4:0];
            SRAV:        r = $signed(rt) >>> rs[4:0];
            ADDI, ADDIU: r = rs + sImm;
            ANDI:        r = rs & zImm;
            ORI:         r = rs | zImm;
            XORI:        r = rs ^ zImm;
            SLTI:        r = ($signed(rs) < $signed(sImm)) ? 32'd1 : 32'd0;
            SLTIU:       r = (rs < sImm) ? 32'd1 : 32'd0;
            LUI:         r = {imm, 16'h0000};
            LW, SW:      r = rs + sImm;     // Effective address
            default:     r = '0;            // NOP and JAL
        endcase
        return r;
    endfunction

    function automatic exMemT expectedStage(input exInT vec, input fwdT memSrc,
                                            input fwdT wbSrc);
        exMemT e;
        wordT  rs;
        wordT  rt;

        rs = forwardedValue(vec.rsAddr, vec.dataRs, memSrc, wbSrc);
        rt = forwardedValue(vec.rtAddr, vec.dataRt, memSrc, wbSrc);
        e.instr        = vec.instr;
        e.pc           = vec.pc;
        e.aluOut       = expectedAlu(vec.instr, rs, rt, vec.imm16, vec.shamt);
        e.memWriteData = rt;
        e.regWriteAddr = vec.regWriteAddr;
        if (vec.instr inside {NOP, LW, SW, JAL})
            e.regWriteData = vec.regWriteData;
        else
            e.regWriteData = e.aluOut;
        return e;
    endfunction

    function automatic exInT randomInput(input instrT op);
        exInT v;

        v.instr        = op;
        v.pc           = $random(seed) & 32'hFFFF_FFFC;
        v.rsAddr       = $random(seed);
        v.rtAddr       = $random(seed);
        v.dataRs       = $random(seed);
        v.dataRt       = $random(seed);
        v.imm16        = $random(seed);
        v.shamt        = $random(seed);
        v.regWriteAddr = $random(seed);
        v.regWriteData = $random(seed);
        if (op == NOP)
            v.regWriteAddr = '0;
        else if (v.regWriteAddr == 0)
            v.regWriteAddr = 5'd1;      // Keep a real destination
        return v;
    endfunction

    task automatic compareField(input string name, input wordT expected, input wordT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkStage(input exMemT expected);
        compareField("exMem.instr", expected.instr, exMem.instr);
        compareField("exMem.pc", expected.pc, exMem.pc);
        compareField("exMem.aluOut", expected.aluOut, exMem.aluOut);
        compareField("exMem.memWriteData", expected.memWriteData, exMem.memWriteData);
        compareField("exMem.regWriteAddr", expected.regWriteAddr, exMem.regWriteAddr);
        compareField("exMem.regWriteData", expected.regWriteData, exMem.regWriteData);
    endtask

    // Called 2 ns after an edge and returns 2 ns after the next one
    task automatic applyExpect(input exInT vec, input fwdT memSrc, input fwdT wbSrc,
                               input exMemT expected);
        exIn   = vec;
        fwdMem = memSrc;
        fwdWb  = wbSrc;
        @(posedge clk);
        #1;
        checkStage(expected);
        #1;
    endtask

    task automatic applyVector(input exInT vec, input fwdT memSrc, input fwdT wbSrc);
        applyExpect(vec, memSrc, wbSrc, expectedStage(vec, memSrc, wbSrc));
    endtask

    task automatic checkReset();
        exIn   = randomInput(ADD);      // Ignored while in reset
        fwdMem = '{addr: 5'd1, data: 32'hDEAD_0001};
        fwdWb  = '{addr: 5'd2, data: 32'hDEAD_0002};
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            checkStage('0);
        end
        #1;
        arstN  = 1'b1;
        exIn   = '0;
        fwdMem = NO_FWD;
        fwdWb  = NO_FWD;
        @(negedge clk);
        checkStage('0);                 // Before the first capturing edge
        @(posedge clk);
        #2;
    endtask

    task automatic regRegSweep();
        instrT regOps[10];
        wordT  corners[5];
        exInT  vec;

        regOps  = '{ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU};
        corners = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_0001,
                    32'h7FFF_FFFF};
        foreach (regOps[i]) begin
            for (int k = 0; k < 20; k++) begin
                vec = randomInput(regOps[i]);
                if (k < 5) begin        // Signed and unsigned order disagree
                    vec.dataRs = corners[k];
                    vec.dataRt = corners[4-k];
                end
                applyVector(vec, NO_FWD, NO_FWD);
            end
        end
    endtask

    task automatic immediateSweep();
        instrT immOps[10];
        imm16T immVals[4];
        exInT  vec;

        immOps  = '{ADDI, ADDIU, ANDI, ORI, XORI, SLTI, SLTIU, LUI, LW, SW};
        immVals = '{16'h8004, 16'h7FF0, 16'hFFFF, 16'h0001};
        foreach (immOps[i]) begin
            foreach (immVals[k]) begin
                vec       = randomInput(immOps[i]);
                vec.imm16 = immVals[k];
                applyVector(vec, NO_FWD, NO_FWD);
            end
        end

        // Extension spot checks with known answers
        vec        = randomInput(ADDI);
        vec.dataRs = '0;
        vec.imm16  = 16'h8000;
        applyVector(vec, NO_FWD, NO_FWD);
        compareField("exMem.aluOut (ADDI sign extension)", 32'hFFFF_8000, exMem.aluOut);
        vec        = randomInput(ORI);
        vec.dataRs = '0;
        vec.imm16  = 16'h8000;
        applyVector(vec, NO_FWD, NO_FWD);
        compareField("exMem.aluOut (ORI zero extension)", 32'h0000_8000, exMem.aluOut);

        // JAL writes back the link value from decode
        repeat (3) begin
            vec              = randomInput(JAL);
            vec.regWriteAddr = 5'd31;
            vec.regWriteData = vec.pc + 32'd8;
            applyVector(vec, NO_FWD, NO_FWD);
        end
    endtask

    task automatic shiftSweep();
        instrT shiftOps[6];
        shamtT amounts[6];
        exInT  vec;

        shiftOps = '{SLL, SRL, SRA, SLLV, SRLV, SRAV};
        amounts  = '{5'd0, 5'd1, 5'd31, 5'd4, 5'd16, 5'd27};
        foreach (shiftOps[i]) begin
            foreach (amounts[k]) begin
                vec       = randomInput(shiftOps[i]);
                vec.shamt = amounts[k];
                vec.dataRs[4:0] = amounts[5-k]; // Never equal to the shamt field
                if (k < 3)
                    vec.dataRt = 32'h8765_4321; // Negative so the fill shows
                applyVector(vec, NO_FWD, NO_FWD);
            end
        end
    endtask

    task automatic forwardingCases();
        exInT vec;
        fwdT  memSrc;
        fwdT  wbSrc;

        // MEM match on rs
        vec        = randomInput(SUB);
        vec.rsAddr = 5'd8;
        vec.rtAddr = 5'd9;
        memSrc     = '{addr: 5'd8, data: 32'h1111_0000};
        wbSrc      = '{addr: 5'd12, data: 32'h2222_0000};
        applyVector(vec, memSrc, wbSrc);
        compareField("exMem.aluOut (rs from MEM)", 32'h1111_0000 - vec.dataRt, exMem.aluOut);

        // WB only match on rt
        memSrc.addr = 5'd3;
        wbSrc.addr  = 5'd9;
        applyVector(vec, memSrc, wbSrc);

        // Both match rs and rt
        vec.rtAddr  = 5'd8;
        memSrc.addr = 5'd8;
        wbSrc.addr  = 5'd8;
        applyVector(vec, memSrc, wbSrc);

        // Zero register keeps the decode value
        vec.rsAddr  = 5'd0;
        vec.rtAddr  = 5'd0;
        memSrc.addr = 5'd0;
        wbSrc.addr  = 5'd0;
        applyVector(vec, memSrc, wbSrc);

        // Store data taken from MEM
        vec        = randomInput(SW);
        vec.rsAddr = 5'd4;
        vec.rtAddr = 5'd17;
        memSrc     = '{addr: 5'd17, data: 32'hCAFE_F00D};
        wbSrc      = '{addr: 5'd17, data: 32'h0BAD_0BAD};
        applyVector(vec, memSrc, wbSrc);
        compareField("exMem.memWriteData (SW from MEM)", 32'hCAFE_F00D, exMem.memWriteData);
    endtask

    task automatic stallAndClear();
        exInT  held;
        exMemT heldOut;

        held    = randomInput(ORI);
        heldOut = expectedStage(held, NO_FWD, NO_FWD);
        applyVector(held, NO_FWD, NO_FWD);

        stall = 1'b1;
        repeat (4) applyExpect(randomInput(SUB), NO_FWD, NO_FWD, heldOut);

        clr = 1'b1;     // Stall still high
        applyExpect(randomInput(ADD), NO_FWD, NO_FWD, '0);
        applyExpect(randomInput(XOR), NO_FWD, NO_FWD, '0);

        stall = 1'b0;
        clr   = 1'b0;
        applyVector(randomInput(NOR), NO_FWD, NO_FWD);
        applyVector(randomInput(SLT), NO_FWD, NO_FWD);
    endtask

    initial begin
        seed   = 96485;
        errors = 0;
        checks = 0;
        arstN  = 1'b0;
        stall  = 1'b0;
        clr    = 1'b0;
        exIn   = '0;
        fwdMem = NO_FWD;
        fwdWb  = NO_FWD;

        checkReset();
        regRegSweep();
        immediateSweep();
        shiftSweep();
        forwardingCases();
        stallAndClear();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
exPkg.sv
instrClassifier.sv
alu.sv
forwardUnit.sv
exStage.sv
exStageTb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - .
    files:
      - exPkg.sv
      - instrClassifier.sv
      - alu.sv
      - forwardUnit.sv
      - exStage.sv
  - target: test
    files:
      - exStageTb.sv
